/* logic/video_pkg.sv */
package video_pkg;

	// ====================
	// Pixel and byte types
	// ====================

	typedef logic [23:0] pixel_t;      // RGB888, red in [23:16], blue in [7:0]
	typedef logic [7:0]  cam_byte_t;   // One byte off the OV7670 data bus

	// Raster counter width, enough for any common format
	localparam int COORD_BITS = 12;

	// ====================
	// 640x480p defaults
	// ====================

	// Horizontal, in pixel clocks
	localparam int DEF_H_ACTIVE = 640;
	localparam int DEF_H_FP     = 16;
	localparam int DEF_H_SYNC   = 96;
	localparam int DEF_H_BP     = 48;

	// Vertical, in lines
	localparam int DEF_V_ACTIVE = 480;
	localparam int DEF_V_FP     = 10;
	localparam int DEF_V_SYNC   = 2;
	localparam int DEF_V_BP     = 33;

	// Pixel FIFO, power of two
	localparam int DEF_FIFO_DEPTH = 1024;

	// Drop and underrun counter width
	localparam int DROP_BITS = 16;

	// ====================
	// Colours
	// ====================

	localparam pixel_t BLACK = 24'h000000;   // Shown on underrun and in blanking

endpackage

/* logic/cam_capture.sv */
`timescale 1ns/10ps

module cam_capture (
	input  logic                              clk_25_2m,
	input  logic                              reset,
	input  logic                              cam_pclk,     // Camera pixel clock, async
	input  logic                              cam_href,     // High while a line is sent
	input  logic                              cam_vsync,    // High during frame blanking
	input  video_pkg::cam_byte_t              cam_data,
	input  logic                              fifo_full,
	output logic                              fifo_wr,
	output video_pkg::pixel_t                 fifo_wdata,
	output logic [video_pkg::DROP_BITS-1:0]   drop_count
);
	import video_pkg::*;

	logic [1:0] pclk_sync, href_sync, vsync_sync;   // Two-flop synchronizers, [1] is safe
	cam_byte_t  data_meta, data_s;                  // Data rides the same two stages
	logic       pclk_prev;                          // For the rising edge detect
	logic       pclk_rise;
	logic       lo_phase;                           // Next byte is the low byte
	logic       pair_done;                          // Low byte taken last cycle
	cam_byte_t  hi_byte, lo_byte;

	// RGB565 to RGB888, top bits of each field repeat into the bottom
	function automatic pixel_t expand565(input cam_byte_t hi, input cam_byte_t lo);
		logic [4:0] r5;
		logic [5:0] g6;
		logic [4:0] b5;
		r5 = hi[7:3];
		g6 = {hi[2:0], lo[7:5]};
		b5 = lo[4:0];
		return {r5, r5[4:2], g6, g6[5:4], b5, b5[4:2]};
	endfunction

	// ====================
	// Pin synchronizers
	// ====================
	always_ff @(posedge clk_25_2m) begin
		if (!reset) begin
			pclk_sync  <= '0;
			href_sync  <= '0;
			vsync_sync <= '0;
			pclk_prev  <= 1'b0;   // No false edge straight out of reset
		end else begin
			pclk_sync  <= {pclk_sync[0], cam_pclk};
			href_sync  <= {href_sync[0], cam_href};
			vsync_sync <= {vsync_sync[0], cam_vsync};
			pclk_prev  <= pclk_sync[1];
		end
	end

	always_ff @(posedge clk_25_2m) begin
		data_meta <= cam_data;
		data_s    <= data_meta;
	end

	assign pclk_rise = pclk_sync[1] & ~pclk_prev;

	// ====================
	// Byte pairing
	// ====================
	// Phase clears in VSYNC and whenever HREF is low, so the first byte after
	// an HREF rise is always a high byte even after an odd byte count
	always_ff @(posedge clk_25_2m) begin
		if (!reset) begin
			lo_phase  <= 1'b0;
			pair_done <= 1'b0;
		end else begin
			pair_done <= 1'b0;                     // One-cycle pulse
			if (vsync_sync[1] || !href_sync[1]) begin
				lo_phase <= 1'b0;
			end else if (pclk_rise) begin
				lo_phase  <= ~lo_phase;
				pair_done <= lo_phase;             // Pair complete on the low byte
			end
		end
	end

	always_ff @(posedge clk_25_2m) begin
		if (pclk_rise && href_sync[1] && !vsync_sync[1]) begin
			if (lo_phase)
				lo_byte <= data_s;                 // RGB565 bits 7:0
			else
				hi_byte <= data_s;                 // RGB565 bits 15:8
		end
	end

	// ====================
	// FIFO write or drop
	// ====================
	always_ff @(posedge clk_25_2m) begin
		if (!reset) begin
			fifo_wr    <= 1'b0;
			drop_count <= '0;
		end else begin
			fifo_wr <= pair_done & ~fifo_full;
			if (pair_done && fifo_full && drop_count != '1)
				drop_count <= drop_count + 1'b1;   // Saturates at all ones
		end
	end

	always_ff @(posedge clk_25_2m) begin
		if (pair_done)
			fifo_wdata <= expand565(hi_byte, lo_byte);
	end

	// Camera cannot be stalled, a full FIFO must turn the pixel into a drop
	a_no_wr_when_full: assert property (@(posedge clk_25_2m) disable iff (!reset)
		fifo_wr |-> !fifo_full);

endmodule

/* logic/pixel_fifo.sv */
`timescale 1ns/10ps

module pixel_fifo #(
	parameter int FIFO_DEPTH = video_pkg::DEF_FIFO_DEPTH   // Power of two
) (
	input  logic              clk_25_2m,
	input  logic              reset,
	input  logic              fifo_wr,      // Write request from the camera side
	input  video_pkg::pixel_t fifo_wdata,
	input  logic              fifo_rd,      // Read request, removes the head
	output video_pkg::pixel_t fifo_rdata,   // Head word, valid while not empty
	output logic              fifo_full,
	output logic              fifo_empty
);
	import video_pkg::*;

	localparam int ADDR_BITS = $clog2(FIFO_DEPTH);

	// ====================
	// Storage and pointers
	// ====================

	pixel_t mem [FIFO_DEPTH];                // Circular buffer

	// Extra top bit tells a full wrap from an empty match
	logic [ADDR_BITS:0] wr_ptr;
	logic [ADDR_BITS:0] rd_ptr;
	logic               do_wr;
	logic               do_rd;

	assign do_wr = fifo_wr & ~fifo_full;     // Guarded anyway
	assign do_rd = fifo_rd & ~fifo_empty;

	// Pointers equal means empty
	assign fifo_empty = (wr_ptr == rd_ptr);

	// Same slot one lap apart means full
	assign fifo_full = (wr_ptr[ADDR_BITS] != rd_ptr[ADDR_BITS])
		&& (wr_ptr[ADDR_BITS-1:0] == rd_ptr[ADDR_BITS-1:0]);

	assign fifo_rdata = mem[rd_ptr[ADDR_BITS-1:0]];   // Show-ahead head word

	always_ff @(posedge clk_25_2m) begin
		if (!reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			// Write and read in one cycle both advance
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk_25_2m) begin
		if (do_wr)
			mem[wr_ptr[ADDR_BITS-1:0]] <= fifo_wdata;
	end

	// ====================
	// Protocol checks
	// ====================

	// Scanout must only pop a head that exists
	a_no_rd_when_empty: assert property (@(posedge clk_25_2m) disable iff (!reset)
		fifo_rd |-> !fifo_empty);

	// Capture side turns a full FIFO into a drop
	a_no_wr_when_full: assert property (@(posedge clk_25_2m) disable iff (!reset)
		fifo_wr |-> !fifo_full);

endmodule

/* logic/video_timing.sv */
`timescale 1ns/10ps

module video_timing #(
	parameter int H_ACTIVE = video_pkg::DEF_H_ACTIVE,   // Visible pixels per line
	parameter int H_FP     = video_pkg::DEF_H_FP,
	parameter int H_SYNC   = video_pkg::DEF_H_SYNC,
	parameter int H_BP     = video_pkg::DEF_H_BP,
	parameter int V_ACTIVE = video_pkg::DEF_V_ACTIVE,   // Visible lines per frame
	parameter int V_FP     = video_pkg::DEF_V_FP,
	parameter int V_SYNC   = video_pkg::DEF_V_SYNC,
	parameter int V_BP     = video_pkg::DEF_V_BP
) (
	input  logic clk_25_2m,
	input  logic reset,
	output logic raw_de,   // Active video, combinational
	output logic raw_hs,   // Active low
	output logic raw_vs    // Active low
);
	import video_pkg::*;

	// ====================
	// Raster boundaries
	// ====================

	// Line and frame order: active, front porch, sync, back porch
	localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP;
	localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP;

	localparam logic [COORD_BITS-1:0] H_LAST       = COORD_BITS'(H_TOTAL - 1);
	localparam logic [COORD_BITS-1:0] H_DE_END     = COORD_BITS'(H_ACTIVE);
	localparam logic [COORD_BITS-1:0] H_SYNC_START = COORD_BITS'(H_ACTIVE + H_FP);
	localparam logic [COORD_BITS-1:0] H_SYNC_END   = COORD_BITS'(H_ACTIVE + H_FP + H_SYNC);

	localparam logic [COORD_BITS-1:0] V_LAST       = COORD_BITS'(V_TOTAL - 1);
	localparam logic [COORD_BITS-1:0] V_DE_END     = COORD_BITS'(V_ACTIVE);
	localparam logic [COORD_BITS-1:0] V_SYNC_START = COORD_BITS'(V_ACTIVE + V_FP);
	localparam logic [COORD_BITS-1:0] V_SYNC_END   = COORD_BITS'(V_ACTIVE + V_FP + V_SYNC);

	logic [COORD_BITS-1:0] h_count;   // Pixel within the line
	logic [COORD_BITS-1:0] v_count;   // Line within the frame
	logic                  h_wrap;
	logic                  v_wrap;

	assign h_wrap = (h_count == H_LAST);
	assign v_wrap = (v_count == V_LAST);

	// ====================
	// Counters
	// ====================
	// Both start at zero, first active pixel right after reset
	always_ff @(posedge clk_25_2m) begin
		if (!reset) begin
			h_count <= '0;
			v_count <= '0;
		end else if (h_wrap) begin
			h_count <= '0;
			if (v_wrap)
				v_count <= '0;                   // New frame
			else
				v_count <= v_count + 1'b1;       // Next line
		end else begin
			h_count <= h_count + 1'b1;
		end
	end

	// ====================
	// Decode
	// ====================

	assign raw_de = (h_count < H_DE_END) && (v_count < V_DE_END);

	// Sync pulses low inside their window
	assign raw_hs = !((h_count >= H_SYNC_START) && (h_count < H_SYNC_END));
	assign raw_vs = !((v_count >= V_SYNC_START) && (v_count < V_SYNC_END));

	// Horizontal sync sits wholly in blanking for any legal parameter set
	a_de_not_in_hsync: assert property (@(posedge clk_25_2m) disable iff (!reset)
		raw_de |-> raw_hs);

endmodule

/* logic/pixel_scanout.sv */
`timescale 1ns/10ps

module pixel_scanout (
	input  logic                             clk_25_2m,
	input  logic                             reset,
	input  logic                             raw_de,
	input  logic                             raw_hs,
	input  logic                             raw_vs,
	input  video_pkg::pixel_t                fifo_rdata,
	input  logic                             fifo_empty,
	output logic                             fifo_rd,      // Pops the head this cycle
	output logic                             hdmi_de,
	output logic                             hdmi_hs,
	output logic                             hdmi_vs,
	output video_pkg::pixel_t                hdmi_d,
	output logic                             underrun,     // Black shown for lack of data
	output logic [video_pkg::DROP_BITS-1:0]  underrun_count
);
	import video_pkg::*;

	logic starved;   // Active cycle with nothing to show

	// One pixel per active cycle, only if there is one
	assign fifo_rd = raw_de & ~fifo_empty;
	assign starved = raw_de & fifo_empty;

	// ====================
	// HDMI output register
	// ====================
	// Every output leaves through this one stage, so DE, syncs and data stay aligned
	always_ff @(posedge clk_25_2m) begin
		if (!reset) begin
			hdmi_de        <= 1'b0;
			hdmi_hs        <= 1'b1;    // Syncs idle high
			hdmi_vs        <= 1'b1;
			hdmi_d         <= BLACK;
			underrun       <= 1'b0;
			underrun_count <= '0;
		end else begin
			hdmi_de  <= raw_de;
			hdmi_hs  <= raw_hs;
			hdmi_vs  <= raw_vs;
			hdmi_d   <= fifo_rd ? fifo_rdata : BLACK;   // Blanking and underrun show black
			underrun <= starved;
			if (starved && underrun_count != '1)
				underrun_count <= underrun_count + 1'b1;  // Saturates
		end
	end

endmodule

/* logic/img_cap_top.sv */
`timescale 1ns/10ps

module img_cap_top #(
	parameter int H_ACTIVE   = video_pkg::DEF_H_ACTIVE,
	parameter int H_FP       = video_pkg::DEF_H_FP,
	parameter int H_SYNC     = video_pkg::DEF_H_SYNC,
	parameter int H_BP       = video_pkg::DEF_H_BP,
	parameter int V_ACTIVE   = video_pkg::DEF_V_ACTIVE,
	parameter int V_FP       = video_pkg::DEF_V_FP,
	parameter int V_SYNC     = video_pkg::DEF_V_SYNC,
	parameter int V_BP       = video_pkg::DEF_V_BP,
	parameter int FIFO_DEPTH = video_pkg::DEF_FIFO_DEPTH
) (
	input  logic                             clk_25_2m,
	input  logic                             reset,
	input  logic                             cam_pclk,
	input  logic                             cam_href,
	input  logic                             cam_vsync,
	input  video_pkg::cam_byte_t             cam_data,
	output logic                             hdmi_clk,
	output logic                             hdmi_de,
	output logic                             hdmi_hs,
	output logic                             hdmi_vs,
	output video_pkg::pixel_t                hdmi_d,
	output logic                             underrun,
	output logic [video_pkg::DROP_BITS-1:0]  drop_count,
	output logic [video_pkg::DROP_BITS-1:0]  underrun_count
);
	import video_pkg::*;

	logic   fifo_wr, fifo_rd, fifo_full, fifo_empty;
	pixel_t fifo_wdata, fifo_rdata;
	logic   raw_de, raw_hs, raw_vs;   // Unregistered raster

	assign hdmi_clk = clk_25_2m;      // Transmitter samples on the same clock

	// ====================
	// Camera to FIFO
	// ====================
	cam_capture u_cam_capture (
		.clk_25_2m, .reset, .cam_pclk, .cam_href, .cam_vsync, .cam_data,
		.fifo_full, .fifo_wr, .fifo_wdata, .drop_count
	);

	pixel_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_pixel_fifo (
		.clk_25_2m, .reset, .fifo_wr, .fifo_wdata, .fifo_rd,
		.fifo_rdata, .fifo_full, .fifo_empty
	);

	// ====================
	// Raster and scanout
	// ====================
	video_timing #(
		.H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
		.V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
	) u_video_timing (
		.clk_25_2m, .reset, .raw_de, .raw_hs, .raw_vs
	);

	pixel_scanout u_pixel_scanout (
		.clk_25_2m, .reset, .raw_de, .raw_hs, .raw_vs, .fifo_rdata, .fifo_empty,
		.fifo_rd, .hdmi_de, .hdmi_hs, .hdmi_vs, .hdmi_d, .underrun, .underrun_count
	);

endmodule

/* sim/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen #(
	parameter int HALF_NS      = 20,   // 40 ns period
	parameter int RESET_CYCLES = 8
) (
	output logic clk_25_2m,
	output logic reset
);

	initial begin
		clk_25_2m = 1'b0;
		forever #(HALF_NS) clk_25_2m = ~clk_25_2m;
	end

	// Active low, released on a falling edge after RESET_CYCLES rising edges
	initial begin
		reset = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk_25_2m);
		reset = 1'b1;
	end

endmodule

/* sim/img_cap_checker.sv */
`timescale 1ns/10ps

module img_cap_checker #(
	parameter int H_ACTIVE     = video_pkg::DEF_H_ACTIVE,
	parameter int H_SYNC       = video_pkg::DEF_H_SYNC,
	parameter int H_TOTAL      = 800,   // Cycles per line
	parameter int V_SYNC       = video_pkg::DEF_V_SYNC,
	parameter int V_TOTAL      = 525,   // Lines per frame
	parameter int EXPECT_DROPS = 0      // Total drops for the whole run
) (
	input  logic                            clk_25_2m,
	input  logic                            reset,
	input  logic                            cam_pclk,
	input  logic                            cam_href,
	input  logic                            cam_vsync,
	input  video_pkg::cam_byte_t            cam_data,
	input  logic                            hdmi_clk,
	input  logic                            hdmi_de,
	input  logic                            hdmi_hs,
	input  logic                            hdmi_vs,
	input  video_pkg::pixel_t               hdmi_d,
	input  logic                            underrun,
	input  logic [video_pkg::DROP_BITS-1:0] drop_count,
	input  logic [video_pkg::DROP_BITS-1:0] underrun_count,
	input  logic                            end_check,   // Run the closing checks
	output int                              errors
);
	import video_pkg::*;

	pixel_t    exp_q[$];                         // Pixels sent and not yet shown
	logic      reset_s, pclk_s, href_s, vsync_s, end_s;
	cam_byte_t data_s;                           // Pins as sampled on the rising edge
	logic      pclk_last, lo_next, end_done;
	cam_byte_t hi_keep;                          // High byte waiting for its partner
	logic      de_last, hs_last, vs_last;
	int        cyc, de_run, hs_run, vs_run;
	int        hs_fall_at, vs_fall_at;           // -1 until the first edge
	int        n_under, n_drop;
	int        hclk_rises;                       // hdmi_clk rises in step with clk_25_2m
	int        hclk_seen;

	// RGB565 pair to RGB888 with each field widened by repeating its top bits
	function automatic pixel_t rgb565_to_888(input cam_byte_t hi, input cam_byte_t lo);
		logic [15:0] w;
		logic [7:0]  r, g, b;
		w = {hi, lo};
		r = {w[15:11], 3'b000} | {5'b00000, w[15:13]};
		g = {w[10:5], 2'b00} | {6'b000000, w[10:9]};
		b = {w[4:0], 3'b000} | {5'b00000, w[4:2]};
		return {r, g, b};
	endfunction

	task automatic report_error(input string msg);
		errors++;
		$display("Error at %0t: %s", $time, msg);
	endtask

	// ====================
	// Camera side model
	// ====================
	task automatic model_camera();
		if (vsync_s || !href_s) begin
			lo_next = 1'b0;                      // Pairing restarts on a high byte
		end else if (pclk_s && !pclk_last) begin
			if (lo_next)
				exp_q.push_back(rgb565_to_888(hi_keep, data_s));
			else
				hi_keep = data_s;
			lo_next = !lo_next;
		end
		pclk_last = pclk_s;
	endtask

	// A drop always hits the newest pixel since it is the one still in flight
	task automatic track_drops();
		if (int'(drop_count) == n_drop + 1) begin
			n_drop++;
			if (exp_q.size() == 0)
				report_error("drop counted with no pixel in flight");
			else
				void'(exp_q.pop_back());
		end else if (int'(drop_count) != n_drop) begin
			report_error($sformatf("drop_count moved from %0d to %0d", n_drop, drop_count));
			n_drop = int'(drop_count);
		end
	endtask

	// ====================
	// Pixel and raster checks
	// ====================
	task automatic check_pixel();
		pixel_t want;
		if (!hdmi_de) begin
			if (underrun)
				report_error("underrun high outside active video");
			if (hdmi_d !== BLACK)
				report_error($sformatf("blanking shows %h, expected black", hdmi_d));
		end else if (underrun) begin
			n_under++;
			if (hdmi_d !== BLACK)
				report_error($sformatf("underrun shows %h, expected black", hdmi_d));
		end else if (exp_q.size() == 0) begin
			report_error($sformatf("pixel %h shown with none sent, expected underrun", hdmi_d));
		end else begin
			want = exp_q.pop_front();
			if (hdmi_d !== want)
				report_error($sformatf("pixel %h, expected %h", hdmi_d, want));
		end
	endtask

	task automatic check_raster();
		if (hdmi_de) begin
			de_run++;
		end else if (de_last) begin
			if (de_run != H_ACTIVE)
				report_error($sformatf("DE run of %0d cycles, expected %0d", de_run, H_ACTIVE));
			de_run = 0;
		end
		if (!hdmi_hs) begin
			hs_run++;
			if (hs_last) begin                   // HSYNC falling edge
				if (hs_fall_at >= 0 && cyc - hs_fall_at != H_TOTAL)
					report_error($sformatf("line period %0d", cyc - hs_fall_at));
				hs_fall_at = cyc;
			end
		end else if (!hs_last) begin
			if (hs_run != H_SYNC)
				report_error($sformatf("HSYNC low for %0d cycles", hs_run));
			hs_run = 0;
		end
		if (!hdmi_vs) begin
			vs_run++;
			if (vs_last) begin                   // VSYNC falling edge
				if (vs_fall_at >= 0 && cyc - vs_fall_at != H_TOTAL * V_TOTAL)
					report_error($sformatf("frame period %0d cycles", cyc - vs_fall_at));
				vs_fall_at = cyc;
			end
		end else if (!vs_last) begin
			if (vs_run != H_TOTAL * V_SYNC)
				report_error($sformatf("VSYNC low for %0d cycles", vs_run));
			vs_run = 0;
		end
		de_last = hdmi_de;
		hs_last = hdmi_hs;
		vs_last = hdmi_vs;
	endtask

	// One in-phase hdmi_clk rise per system clock cycle
	task automatic check_hdmi_clk();
		if (hclk_rises != hclk_seen + 1)
			report_error($sformatf("%0d hdmi_clk rises in one cycle, expected 1",
				hclk_rises - hclk_seen));
		hclk_seen = hclk_rises;
	endtask

	task automatic run_final_checks();
		end_done = 1'b1;
		if (exp_q.size() != 0)
			report_error($sformatf("%0d sent pixels never shown", exp_q.size()));
		if (int'(drop_count) != EXPECT_DROPS)
			report_error($sformatf("drop_count %0d, expected %0d", drop_count, EXPECT_DROPS));
		if (int'(underrun_count) != n_under)
			report_error($sformatf("underrun_count %0d, expected %0d", underrun_count, n_under));
		if (hs_fall_at < 0 || vs_fall_at < 0)
			report_error("HSYNC or VSYNC never pulsed");
	endtask

	// Counted only when the system clock is already high
	always @(posedge hdmi_clk) begin
		if (clk_25_2m === 1'b1)
			hclk_rises++;
	end

	// Pins and control are taken on the rising edge and DUT outputs on the falling edge
	always @(posedge clk_25_2m) begin
		reset_s <= reset;
		pclk_s  <= cam_pclk;
		href_s  <= cam_href;
		vsync_s <= cam_vsync;
		data_s  <= cam_data;
		end_s   <= end_check;
	end

	always @(negedge clk_25_2m) begin
		if (!reset_s) begin
			errors     = 0;
			exp_q.delete();
			pclk_last  = 1'b0;
			lo_next    = 1'b0;
			end_done   = 1'b0;
			de_last    = 1'b0;
			hs_last    = 1'b1;                   // Syncs idle high
			vs_last    = 1'b1;
			cyc        = 0;
			de_run     = 0;
			hs_run     = 0;
			vs_run     = 0;
			hs_fall_at = -1;
			vs_fall_at = -1;
			n_under    = 0;
			n_drop     = 0;
			hclk_seen  = hclk_rises;
		end else begin
			cyc++;
			model_camera();                      // Push before any pop this cycle
			track_drops();
			check_pixel();
			check_raster();
			check_hdmi_clk();
			if (end_s && !end_done)
				run_final_checks();
		end
	end

endmodule

/* sim/img_cap_tb.sv */
`timescale 1ns/10ps

module img_cap_tb;
	import video_pkg::*;

	// Small raster so a frame is only 192 cycles
	localparam int H_ACTIVE   = 16;
	localparam int H_FP       = 2;
	localparam int H_SYNC     = 3;
	localparam int H_BP       = 3;
	localparam int V_ACTIVE   = 4;
	localparam int V_FP       = 1;
	localparam int V_SYNC     = 1;
	localparam int V_BP       = 2;
	localparam int FIFO_DEPTH = 16;
	localparam int H_TOTAL    = H_ACTIVE + H_FP + H_SYNC + H_BP;
	localparam int V_TOTAL    = V_ACTIVE + V_FP + V_SYNC + V_BP;
	localparam int WAIT_LIMIT = 4 * H_TOTAL * V_TOTAL;   // Four frames of cycles
	localparam int BURST_PIX  = 24;                      // Overflow burst
	localparam logic [31:0] SEED = 32'h07a04a56;

	logic                 clk_25_2m, reset;
	logic                 cam_pclk, cam_href, cam_vsync;
	cam_byte_t            cam_data;
	logic                 hdmi_clk, hdmi_de, hdmi_hs, hdmi_vs, underrun;
	pixel_t               hdmi_d;
	logic [DROP_BITS-1:0] drop_count, underrun_count;
	logic                 end_check;
	int                   check_errors;
	int                   timeouts;

	tb_clock_gen u_clock_gen (.clk_25_2m, .reset);

	img_cap_top #(
		.H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
		.V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP),
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_img_cap_top (
		.clk_25_2m, .reset, .cam_pclk, .cam_href, .cam_vsync, .cam_data,
		.hdmi_clk, .hdmi_de, .hdmi_hs, .hdmi_vs, .hdmi_d, .underrun,
		.drop_count, .underrun_count
	);

	img_cap_checker #(
		.H_ACTIVE(H_ACTIVE), .H_SYNC(H_SYNC), .H_TOTAL(H_TOTAL),
		.V_SYNC(V_SYNC), .V_TOTAL(V_TOTAL), .EXPECT_DROPS(BURST_PIX - FIFO_DEPTH)
	) u_checker (
		.clk_25_2m, .reset, .cam_pclk, .cam_href, .cam_vsync, .cam_data,
		.hdmi_clk, .hdmi_de, .hdmi_hs, .hdmi_vs, .hdmi_d, .underrun, .drop_count,
		.underrun_count, .end_check, .errors(check_errors)
	);

	// ====================
	// Run control
	// ====================
	task automatic close_run();
		@(posedge clk_25_2m);                 // Away from the checker's edge
		$display("Errors: %0d from checks, %0d timeouts", check_errors, timeouts);
		if (check_errors == 0 && timeouts == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	endtask

	// Waits for a falling edge where the chosen raster output sits at level
	task automatic wait_raster(input bit use_vs, input logic level);
		int n;
		n = 0;
		@(negedge clk_25_2m);
		while ((use_vs ? hdmi_vs : hdmi_de) !== level && n < WAIT_LIMIT) begin
			@(negedge clk_25_2m);
			n++;
		end
		if ((use_vs ? hdmi_vs : hdmi_de) !== level) begin
			$display("Timeout: %s never reached %0b", use_vs ? "hdmi_vs" : "hdmi_de", level);
			timeouts++;
			close_run();
		end
	endtask

	task automatic wait_reset_release();
		int n;
		n = 0;
		while (reset !== 1'b1 && n < 64) begin
			@(negedge clk_25_2m);
			n++;
		end
		if (reset !== 1'b1) begin
			$display("Timeout: reset was never released");
			timeouts++;
			close_run();
		end
	endtask

	// ====================
	// Camera stimulus
	// ====================
	task automatic send_byte(input cam_byte_t b, input int half);
		cam_data = b;
		cam_pclk = 1'b0;
		repeat (half) @(negedge clk_25_2m);
		cam_pclk = 1'b1;                       // Byte taken on this edge
		repeat (half) @(negedge clk_25_2m);
	endtask

	task automatic send_line(input int npix, input int half);
		cam_href = 1'b1;
		repeat (2 * npix)
			send_byte(8'($urandom), half);
		cam_href = 1'b0;
		cam_pclk = 1'b0;
	endtask

	task automatic idle(input int n);
		repeat (n) @(negedge clk_25_2m);
	endtask

	initial begin
		cam_pclk  = 1'b0;
		cam_href  = 1'b0;
		cam_vsync = 1'b0;
		cam_data  = '0;
		end_check = 1'b0;
		timeouts  = 0;
		void'($urandom(SEED));                 // One seed for the whole run
		wait_reset_release();

		// Pixel order at the normal rate with pclk every 2 cycles
		wait_raster(1'b1, 1'b0);
		repeat (3) begin
			send_line(12, 2);
			idle(6);
		end

		// Camera idle so the FIFO drains and the raster underruns
		repeat (2) begin
			wait_raster(1'b1, 1'b1);
			wait_raster(1'b1, 1'b0);
		end

		// Odd byte count before HREF drops and rises again
		cam_href = 1'b1;
		repeat (3) send_byte(8'($urandom), 2);
		cam_href = 1'b0;
		cam_pclk = 1'b0;
		idle(4);
		send_line(8, 2);

		// Odd byte count before VSYNC pulses with HREF held high
		cam_href = 1'b1;
		repeat (5) send_byte(8'($urandom), 2);
		cam_vsync = 1'b1;
		idle(4);
		cam_vsync = 1'b0;
		idle(2);
		repeat (16) send_byte(8'($urandom), 2);
		cam_href = 1'b0;
		cam_pclk = 1'b0;

		// ====================
		// Overflow
		// ====================
		// Frame marker first and then the end of the last active line
		// The burst at full rate only fits into the blanking from that point on
		repeat (2) begin
			wait_raster(1'b1, 1'b1);
			wait_raster(1'b1, 1'b0);
		end
		repeat (V_ACTIVE) begin
			wait_raster(1'b0, 1'b1);
			wait_raster(1'b0, 1'b0);
		end
		send_line(BURST_PIX, 1);             // 16 fit and the last 8 are lost

		repeat (2) begin
			wait_raster(1'b1, 1'b1);
			wait_raster(1'b1, 1'b0);
		end
		end_check = 1'b1;
		idle(2);
		close_run();
	end

endmodule

/* img_cap.f */
logic/video_pkg.sv
logic/cam_capture.sv
logic/pixel_fifo.sv
logic/video_timing.sv
logic/pixel_scanout.sv
logic/img_cap_top.sv
sim/tb_clock_gen.sv
sim/img_cap_checker.sv
sim/img_cap_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = img_cap_tb
FILELIST  = img_cap.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "^Regression passed$$" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
